// File: cnn_accel_top.f
common/cnn_pkg.sv
common/bus_pkg.sv
conv_layer/layer_fsm.sv
conv_layer/window_counter.sv
conv_layer/conv_mac.sv
conv_layer/pool_banks.sv
hdl/host_port.sv
hdl/cnn_accel_top.sv
bench/cnn_accel_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
	-f cnn_accel_top.f \
	--top-module cnn_accel_tb \
	-o cnn_accel_sim

sim_status=0
sim_output=$(./obj_dir/cnn_accel_sim 2>&1) || sim_status=$?
echo "$sim_output"

if grep -q "TEST RESULT: PASS" <<< "$sim_output"; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed (exit status $sim_status)"
	exit 1
fi

// File: bench/cnn_accel_tb.sv
module cnn_accel_tb;

	localparam int NUM_TESTS = 5;
	localparam int CYCLE_LIMIT = NUM_TESTS * 500;
	localparam int KER_CENTRE = 0;
	localparam int KER_RANDOM = 1;
	localparam int KER_LARGE = 2;
	localparam int PIX_KEEP = 0;
	localparam int PIX_RAMP = 1;
	localparam int PIX_LFSR = 2;
	localparam bus_pkg::bus_addr_t UNMAPPED_ADDR = 32'h7000_0010;

	// one row per test, read across the arrays
	string test_name [NUM_TESTS] = '{"identity_centre", "random_layer", "relu_floor",
		"saturate", "weights_only"};
	int ker_mode [NUM_TESTS] = '{KER_CENTRE, KER_RANDOM, KER_CENTRE, KER_LARGE, KER_RANDOM};
	int pix_mode [NUM_TESTS] = '{PIX_RAMP, PIX_LFSR, PIX_LFSR, PIX_RAMP, PIX_KEEP};
	cnn_pkg::pixel_t bias_val [NUM_TESTS] = '{16'sd0, 16'sd100, 16'sh8000, 16'sd0, -16'sd50};

	logic clk;
	logic arst_n;
	bus_pkg::bus_addr_t awaddr;
	logic awvalid;
	bus_pkg::bus_data_t wdata;
	logic wvalid;
	bus_pkg::bus_addr_t araddr;
	logic arvalid;
	bus_pkg::bus_data_t rdata;
	logic interrupt_signal;

	logic [15:0] lfsr;
	int cycles = 0;
	cnn_pkg::pixel_t model_pix [cnn_pkg::IMG_DIM * cnn_pkg::IMG_DIM];
	cnn_pkg::pixel_t model_w [cnn_pkg::KER_DIM * cnn_pkg::KER_DIM];
	cnn_pkg::pixel_t model_bias;

	cnn_accel_top i_cnn_accel_top (
		.clk(clk),
		.arst_n(arst_n),
		.awaddr(awaddr),
		.awvalid(awvalid),
		.wdata(wdata),
		.wvalid(wvalid),
		.araddr(araddr),
		.arvalid(arvalid),
		.rdata(rdata),
		.interrupt_signal(interrupt_signal)
	);

	always #4 clk = ~clk;

	task automatic fail_now(input string msg);
		$display("%s", msg);
		$display("TEST RESULT: FAIL");
		$fatal(1, "simulation stopped");
	endtask

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT)
			fail_now("timeout: the layer runs did not finish within the cycle limit");
	end

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic take_bits(input int n, output logic [15:0] v);
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsr_next(lfsr);
			v = {v[14:0], lfsr[0]};
		end
	endtask

	task automatic check_pixel(input string name, input cnn_pkg::pixel_t exp,
		input cnn_pkg::pixel_t act);
		if (act !== exp)
			fail_now($sformatf("[ERROR] %s: expected %0d, actual %0d", name, exp, act));
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp)
			fail_now($sformatf("[ERROR] %s: expected %b, actual %b", name, exp, act));
	endtask

	task automatic check_word(input string name, input bus_pkg::bus_data_t exp,
		input bus_pkg::bus_data_t act);
		if (act !== exp)
			fail_now($sformatf("[ERROR] %s: expected 0x%08h, actual 0x%08h", name, exp, act));
	endtask

	task automatic write_word(input bus_pkg::bus_addr_t addr, input bus_pkg::bus_data_t data);
		@(negedge clk);
		awaddr = addr;
		wdata = data;
		awvalid = 1'b1;
		wvalid = 1'b1;
		@(posedge clk);
	endtask

	// rdata is registered, so it is taken one cycle after the address
	task automatic read_word(input bus_pkg::bus_addr_t addr, output bus_pkg::bus_data_t data);
		@(negedge clk);
		awvalid = 1'b0;
		wvalid = 1'b0;
		araddr = addr;
		arvalid = 1'b1;
		@(negedge clk);
		arvalid = 1'b0;
		data = rdata;
	endtask

	task automatic load_image(input int mode);
		logic [15:0] v;
		for (int idx = 0; idx < cnn_pkg::IMG_DIM * cnn_pkg::IMG_DIM; idx++)
		begin
			if (mode == PIX_RAMP)
				v = 16'(idx * 131 + 7);
			else
				take_bits(16, v);
			model_pix[idx] = v;
			write_word(bus_pkg::PIXEL_BASE + bus_pkg::bus_addr_t'(idx * 4), {16'h0, v});
		end
	endtask

	task automatic load_kernel(input int mode);
		logic [15:0] v;
		for (int t = 0; t < cnn_pkg::KER_DIM * cnn_pkg::KER_DIM; t++)
		begin
			if (mode == KER_CENTRE)
				v = t == 4 ? 16'd256 : 16'd0;
			else if (mode == KER_LARGE)
				v = 16'h7fff;
			else
			begin
				take_bits(8, v);
				v = {{8{v[7]}}, v[7:0]};
			end
			model_w[t] = v;
			write_word(bus_pkg::WEIGHT_BASE + bus_pkg::bus_addr_t'(t * 4), {16'h0, v});
		end
	endtask

	// floor shift, bias, relu, then clamp to 16 bits
	function automatic cnn_pkg::pixel_t conv_point(input int r, input int c);
		longint s;
		s = 0;
		for (int i = 0; i < cnn_pkg::KER_DIM; i++)
			for (int j = 0; j < cnn_pkg::KER_DIM; j++)
				s += longint'(model_pix[(r + i) * cnn_pkg::IMG_DIM + c + j])
					* longint'(model_w[i * cnn_pkg::KER_DIM + j]);
		s = (s >>> cnn_pkg::FRAC_BITS) + longint'(model_bias);
		if (s < 0)
			return 16'sd0;
		if (s > 32767)
			return 16'sh7fff;
		return cnn_pkg::pixel_t'(s);
	endfunction

	function automatic cnn_pkg::pixel_t pool_point(input int pr, input int pc);
		cnn_pkg::pixel_t m;
		cnn_pkg::pixel_t v;
		m = conv_point(2 * pr, 2 * pc);
		for (int a = 0; a < 2; a++)
			for (int b = 0; b < 2; b++)
			begin
				v = conv_point(2 * pr + a, 2 * pc + b);
				if (v > m)
					m = v;
			end
		return m;
	endfunction

	task automatic wait_irq();
		bus_pkg::bus_data_t d;
		d = '0;
		while (d[0] !== 1'b1)
			read_word(bus_pkg::IRQ_ADDR, d);
	endtask

	task automatic run_row(input int t);
		bus_pkg::bus_data_t d;
		cnn_pkg::pixel_t expected;
		string name;
		name = test_name[t];
		if (pix_mode[t] != PIX_KEEP)
			load_image(pix_mode[t]);
		load_kernel(ker_mode[t]);
		model_bias = bias_val[t];
		write_word(bus_pkg::BIAS_ADDR, {16'h0, bias_val[t]});
		read_word(bus_pkg::IRQ_ADDR, d);
		check_flag($sformatf("%s irq before start", name), 1'b0, d[0]);
		write_word(bus_pkg::START_ADDR, 32'd1);
		read_word(bus_pkg::IRQ_ADDR, d);
		check_flag($sformatf("%s irq while busy", name), 1'b0, d[0]);
		// dropped, the layer is already running
		write_word(bus_pkg::START_ADDR, 32'd1);
		wait_irq();
		check_flag($sformatf("%s irq pin set", name), 1'b1, interrupt_signal);
		// rdata still holds the set flag here
		read_word(UNMAPPED_ADDR, d);
		check_word($sformatf("%s unmapped read", name), '0, d);
		for (int p = 0; p < cnn_pkg::POOL_DIM * cnn_pkg::POOL_DIM; p++)
		begin
			expected = pool_point(p / cnn_pkg::POOL_DIM, p % cnn_pkg::POOL_DIM);
			read_word(bus_pkg::RESULT_BASE + bus_pkg::bus_addr_t'(p * 4), d);
			check_pixel($sformatf("%s result %0d", name, p), expected, d[15:0]);
			check_word($sformatf("%s result %0d word", name, p),
				{{16{expected[15]}}, expected}, d);
		end
		write_word(bus_pkg::IRQ_ADDR, '0);
		read_word(bus_pkg::IRQ_ADDR, d);
		check_flag($sformatf("%s irq cleared", name), 1'b0, d[0]);
		check_flag($sformatf("%s irq pin cleared", name), 1'b0, interrupt_signal);
	endtask

	initial
	begin
		bus_pkg::bus_data_t d;
		clk = 1'b0;
		arst_n = 1'b0;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wvalid = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		lfsr = 16'd97;
		model_bias = '0;
		repeat (10) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;
		read_word(bus_pkg::IRQ_ADDR, d);
		check_flag("irq after reset", 1'b0, d[0]);
		check_flag("irq pin after reset", 1'b0, interrupt_signal);
		for (int t = 0; t < NUM_TESTS; t++)
			run_row(t);
		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

// File: hdl/cnn_accel_top.sv
module cnn_accel_top (
	input  logic              clk,
	input  logic              arst_n,
	input  bus_pkg::bus_addr_t awaddr,
	input  logic              awvalid,
	input  bus_pkg::bus_data_t wdata,
	input  logic              wvalid,
	input  bus_pkg::bus_addr_t araddr,
	input  logic              arvalid,
	output bus_pkg::bus_data_t rdata,
	output logic              interrupt_signal
);

	logic start;
	logic done;
	logic conv_last;
	logic drain_last;
	logic pool_last;
	logic first_tap;
	logic last_tap;
	cnn_pkg::layer_state_t state;
	cnn_pkg::coord_t tap_row;
	cnn_pkg::coord_t tap_col;
	cnn_pkg::coord_t out_row;
	cnn_pkg::coord_t out_col;
	cnn_pkg::tap_t tap;
	cnn_pkg::pool_idx_t pool_idx;
	cnn_pkg::pool_idx_t result_idx;
	cnn_pkg::pixel_t pixel;
	cnn_pkg::pixel_t weight;
	cnn_pkg::pixel_t bias;
	cnn_pkg::pixel_t result;
	cnn_pkg::conv_res_t res;

	host_port i_host_port (
		.clk(clk),
		.arst_n(arst_n),
		.awaddr(awaddr),
		.awvalid(awvalid),
		.wdata(wdata),
		.wvalid(wvalid),
		.araddr(araddr),
		.arvalid(arvalid),
		.rdata(rdata),
		.interrupt_signal(interrupt_signal),
		.start(start),
		.done(done),
		.tap_row(tap_row),
		.tap_col(tap_col),
		.tap(tap),
		.pixel(pixel),
		.weight(weight),
		.bias(bias),
		.result_idx(result_idx),
		.result(result)
	);

	layer_fsm i_layer_fsm (
		.clk(clk),
		.arst_n(arst_n),
		.start(start),
		.conv_last(conv_last),
		.drain_last(drain_last),
		.pool_last(pool_last),
		.state(state),
		.done(done)
	);

	window_counter i_window_counter (
		.clk(clk),
		.arst_n(arst_n),
		.state(state),
		.tap_row(tap_row),
		.tap_col(tap_col),
		.tap(tap),
		.first_tap(first_tap),
		.last_tap(last_tap),
		.out_row(out_row),
		.out_col(out_col),
		.conv_last(conv_last),
		.drain_last(drain_last),
		.pool_last(pool_last),
		.pool_idx(pool_idx)
	);

	conv_mac i_conv_mac (
		.clk(clk),
		.arst_n(arst_n),
		.first_tap(first_tap),
		.last_tap(last_tap),
		.out_row(out_row),
		.out_col(out_col),
		.pixel(pixel),
		.weight(weight),
		.bias(bias),
		.res(res)
	);

	pool_banks i_pool_banks (
		.clk(clk),
		.arst_n(arst_n),
		.res(res),
		.state(state),
		.pool_idx(pool_idx),
		.result_idx(result_idx),
		.result(result)
	);

endmodule

// File: hdl/host_port.sv
module host_port (
	input  logic                clk,
	input  logic                arst_n,
	input  bus_pkg::bus_addr_t  awaddr,
	input  logic                awvalid,
	input  bus_pkg::bus_data_t  wdata,
	input  logic                wvalid,
	input  bus_pkg::bus_addr_t  araddr,
	input  logic                arvalid,
	output bus_pkg::bus_data_t  rdata,
	output logic                interrupt_signal,
	output logic                start,
	input  logic                done,
	input  cnn_pkg::coord_t     tap_row,
	input  cnn_pkg::coord_t     tap_col,
	input  cnn_pkg::tap_t       tap,
	output cnn_pkg::pixel_t     pixel,
	output cnn_pkg::pixel_t     weight,
	output cnn_pkg::pixel_t     bias,
	output cnn_pkg::pool_idx_t  result_idx,
	input  cnn_pkg::pixel_t     result
);

	cnn_pkg::pixel_t pix_mem [cnn_pkg::IMG_DIM * cnn_pkg::IMG_DIM];
	cnn_pkg::pixel_t wgt_mem [cnn_pkg::KER_DIM * cnn_pkg::KER_DIM];
	bus_pkg::bus_wr_t wr;
	bus_pkg::bus_data_t rd_data;
	logic wr_en;
	logic pix_sel;
	logic wgt_sel;
	logic res_sel;
	logic busy;
	logic irq_flag;

	assign wr_en = awvalid && wvalid;
	assign wr = '{addr: awaddr, data: wdata};

	// region decode, index lives in the low word-address bits
	assign pix_sel = wr.addr[31:8] == bus_pkg::PIXEL_BASE[31:8];
	assign wgt_sel = wr.addr[31:6] == bus_pkg::WEIGHT_BASE[31:6]
		&& wr.addr[5:2] < cnn_pkg::tap_t'(cnn_pkg::KER_DIM * cnn_pkg::KER_DIM);
	assign res_sel = araddr[31:6] == bus_pkg::RESULT_BASE[31:6]
		&& araddr[5:2] < cnn_pkg::pool_idx_t'(cnn_pkg::POOL_DIM * cnn_pkg::POOL_DIM);

	assign start = wr_en && wr.addr == bus_pkg::START_ADDR
		&& wr.data == bus_pkg::bus_data_t'(1) && !busy;
	assign result_idx = araddr[5:2];
	assign interrupt_signal = irq_flag;

	always_ff @(posedge clk)
	begin
		if (wr_en && pix_sel)
			pix_mem[wr.addr[7:2]] <= wr.data[15:0];
		if (wr_en && wgt_sel)
			wgt_mem[wr.addr[5:2]] <= wr.data[15:0];
		if (wr_en && wr.addr == bus_pkg::BIAS_ADDR)
			bias <= wr.data[15:0];
		// both land one cycle after the tap address
		pixel <= pix_mem[{tap_row, tap_col}];
		weight <= wgt_mem[tap];
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			busy <= 1'b0;
			irq_flag <= 1'b0;
		end
		else
		begin
			if (start)
				busy <= 1'b1;
			else if (done)
				busy <= 1'b0;
			if (done)
				irq_flag <= 1'b1;
			else if (wr_en && wr.addr == bus_pkg::IRQ_ADDR)
				irq_flag <= 1'b0;
		end
	end

	always_comb
	begin
		rd_data = '0;
		if (araddr == bus_pkg::IRQ_ADDR)
			rd_data = bus_pkg::bus_data_t'(irq_flag);
		else if (res_sel)
			rd_data = {{16{result[15]}}, result};
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			rdata <= '0;
		else if (arvalid)
			rdata <= rd_data;
	end

endmodule

// File: conv_layer/pool_banks.sv
module pool_banks (
	input  logic                  clk,
	input  logic                  arst_n,
	input  cnn_pkg::conv_res_t    res,
	input  cnn_pkg::layer_state_t state,
	input  cnn_pkg::pool_idx_t    pool_idx,
	input  cnn_pkg::pool_idx_t    result_idx,
	output cnn_pkg::pixel_t       result
);

	// banks indexed by {row parity, col parity}
	cnn_pkg::pixel_t bank_mem [4][cnn_pkg::POOL_DIM * cnn_pkg::POOL_DIM];
	cnn_pkg::pixel_t res_mem [cnn_pkg::POOL_DIM * cnn_pkg::POOL_DIM];
	cnn_pkg::pool_idx_t bank_idx;
	cnn_pkg::pool_idx_t pool_wr_idx;
	cnn_pkg::pixel_t max_top;
	cnn_pkg::pixel_t max_bot;
	cnn_pkg::pixel_t max_all;
	cnn_pkg::pixel_t pool_max;
	logic pool_wr;

	function automatic cnn_pkg::pixel_t max2(cnn_pkg::pixel_t a, cnn_pkg::pixel_t b);
		return a > b ? a : b;
	endfunction

	assign bank_idx = cnn_pkg::pool_idx_t'(res.row[2:1])
		* cnn_pkg::pool_idx_t'(cnn_pkg::POOL_DIM) + cnn_pkg::pool_idx_t'(res.col[2:1]);

	assign max_top = max2(bank_mem[0][pool_idx], bank_mem[1][pool_idx]);
	assign max_bot = max2(bank_mem[2][pool_idx], bank_mem[3][pool_idx]);
	assign max_all = max2(max_top, max_bot);
	assign result = res_mem[result_idx];

	always_ff @(posedge clk)
	begin
		if (res.valid)
			bank_mem[{res.row[0], res.col[0]}][bank_idx] <= res.data;
		pool_wr_idx <= pool_idx;
		pool_max <= max_all;
		if (pool_wr)
			res_mem[pool_wr_idx] <= pool_max;
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			pool_wr <= 1'b0;
		else
			pool_wr <= state == cnn_pkg::POOL;
	end

endmodule

// File: conv_layer/conv_mac.sv
module conv_mac (
	input  logic               clk,
	input  logic               arst_n,
	input  logic               first_tap,
	input  logic               last_tap,
	input  cnn_pkg::coord_t    out_row,
	input  cnn_pkg::coord_t    out_col,
	input  cnn_pkg::pixel_t    pixel,
	input  cnn_pkg::pixel_t    weight,
	input  cnn_pkg::pixel_t    bias,
	output cnn_pkg::conv_res_t res
);

	logic first_d;
	logic last_d;
	logic first_s1;
	logic last_s1;
	logic res_valid;
	cnn_pkg::coord_t row_d;
	cnn_pkg::coord_t col_d;
	cnn_pkg::coord_t row_s1;
	cnn_pkg::coord_t col_s1;
	cnn_pkg::coord_t res_row;
	cnn_pkg::coord_t res_col;
	cnn_pkg::acc_t prod_s1;
	cnn_pkg::acc_t acc;
	cnn_pkg::acc_t sum;
	cnn_pkg::acc_t scaled;
	cnn_pkg::pixel_t final_val;
	cnn_pkg::pixel_t res_data;

	// restart on the first tap of each window
	assign sum = first_s1 ? prod_s1 : acc + prod_s1;
	assign scaled = (sum >>> cnn_pkg::FRAC_BITS) + cnn_pkg::acc_t'(bias);

	always_comb
	begin
		if (scaled < 0)
			final_val = '0;
		else if (scaled > 40'sd32767)
			final_val = 16'sh7fff;
		else
			final_val = scaled[15:0];
	end

	assign res = '{valid: res_valid, row: res_row, col: res_col, data: res_data};

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			first_d <= 1'b0;
			last_d <= 1'b0;
			first_s1 <= 1'b0;
			last_s1 <= 1'b0;
			res_valid <= 1'b0;
		end
		else
		begin
			first_d <= first_tap;
			last_d <= last_tap;
			first_s1 <= first_d;
			last_s1 <= last_d;
			res_valid <= last_s1;
		end
	end

	always_ff @(posedge clk)
	begin
		row_d <= out_row;
		col_d <= out_col;
		row_s1 <= row_d;
		col_s1 <= col_d;
		prod_s1 <= cnn_pkg::acc_t'(pixel) * cnn_pkg::acc_t'(weight);
		acc <= sum;
		if (last_s1)
		begin
			res_row <= row_s1;
			res_col <= col_s1;
			res_data <= final_val;
		end
	end

endmodule

// File: conv_layer/window_counter.sv
module window_counter (
	input  logic                  clk,
	input  logic                  arst_n,
	input  cnn_pkg::layer_state_t state,
	output cnn_pkg::coord_t       tap_row,
	output cnn_pkg::coord_t       tap_col,
	output cnn_pkg::tap_t         tap,
	output logic                  first_tap,
	output logic                  last_tap,
	output cnn_pkg::coord_t       out_row,
	output cnn_pkg::coord_t       out_col,
	output logic                  conv_last,
	output logic                  drain_last,
	output logic                  pool_last,
	output cnn_pkg::pool_idx_t    pool_idx
);

	logic [1:0] ker_row;
	logic [1:0] ker_col;
	logic [1:0] drain_cnt;
	logic in_conv;

	assign in_conv = state == cnn_pkg::CONV;
	assign tap_row = out_row + cnn_pkg::coord_t'(ker_row);
	assign tap_col = out_col + cnn_pkg::coord_t'(ker_col);
	assign first_tap = in_conv && tap == '0;
	assign last_tap = in_conv && tap == cnn_pkg::tap_t'(cnn_pkg::KER_DIM * cnn_pkg::KER_DIM - 1);
	assign conv_last = last_tap && out_row == cnn_pkg::coord_t'(cnn_pkg::CONV_DIM - 1)
		&& out_col == cnn_pkg::coord_t'(cnn_pkg::CONV_DIM - 1);
	assign drain_last = state == cnn_pkg::DRAIN && drain_cnt == 2'd2;
	assign pool_last = state == cnn_pkg::POOL
		&& pool_idx == cnn_pkg::pool_idx_t'(cnn_pkg::POOL_DIM * cnn_pkg::POOL_DIM - 1);

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			tap <= '0;
			ker_row <= '0;
			ker_col <= '0;
			out_row <= '0;
			out_col <= '0;
			drain_cnt <= '0;
			pool_idx <= '0;
		end
		else
		begin
			drain_cnt <= state == cnn_pkg::DRAIN ? drain_cnt + 2'd1 : 2'd0;
			pool_idx <= state == cnn_pkg::POOL ? pool_idx + 4'd1 : 4'd0;
			if (!in_conv)
			begin
				tap <= '0;
				ker_row <= '0;
				ker_col <= '0;
				out_row <= '0;
				out_col <= '0;
			end
			else if (last_tap)
			begin
				// next window, column first
				tap <= '0;
				ker_row <= '0;
				ker_col <= '0;
				if (out_col == cnn_pkg::coord_t'(cnn_pkg::CONV_DIM - 1))
				begin
					out_col <= '0;
					out_row <= conv_last ? '0 : out_row + 3'd1;
				end
				else
					out_col <= out_col + 3'd1;
			end
			else
			begin
				tap <= tap + 4'd1;
				if (ker_col == 2'(cnn_pkg::KER_DIM - 1))
				begin
					ker_col <= '0;
					ker_row <= ker_row + 2'd1;
				end
				else
					ker_col <= ker_col + 2'd1;
			end
		end
	end

endmodule

// File: conv_layer/layer_fsm.sv
module layer_fsm (
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic                  start,
	input  logic                  conv_last,
	input  logic                  drain_last,
	input  logic                  pool_last,
	output cnn_pkg::layer_state_t state,
	output logic                  done
);

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state <= cnn_pkg::IDLE;
			done <= 1'b0;
		end
		else
		begin
			// done is high while in DONE
			done <= state == cnn_pkg::POOL && pool_last;
			case (state)
				cnn_pkg::IDLE:
					if (start)
						state <= cnn_pkg::CONV;
				cnn_pkg::CONV:
					if (conv_last)
						state <= cnn_pkg::DRAIN;
				// mac pipeline empties here
				cnn_pkg::DRAIN:
					if (drain_last)
						state <= cnn_pkg::POOL;
				cnn_pkg::POOL:
					if (pool_last)
						state <= cnn_pkg::DONE;
				cnn_pkg::DONE:
					state <= cnn_pkg::IDLE;
				default:
					state <= cnn_pkg::IDLE;
			endcase
		end
	end

endmodule

// File: common/bus_pkg.sv
package bus_pkg;

	typedef logic [31:0] bus_addr_t;
	typedef logic [31:0] bus_data_t;

	// one word per entry, 4-byte stride
	localparam bus_addr_t PIXEL_BASE = 32'h1000_0000;
	localparam bus_addr_t WEIGHT_BASE = 32'h2000_0000;
	localparam bus_addr_t BIAS_ADDR = 32'h3000_0000;
	localparam bus_addr_t START_ADDR = 32'h4000_0000;
	localparam bus_addr_t IRQ_ADDR = 32'h5000_0000;
	localparam bus_addr_t RESULT_BASE = 32'hd000_0000;

	typedef struct packed {
		bus_addr_t addr;
		bus_data_t data;
	} bus_wr_t;

endpackage

// File: common/cnn_pkg.sv
package cnn_pkg;

	typedef logic signed [15:0] pixel_t;
	typedef logic signed [39:0] acc_t;
	typedef logic [2:0] coord_t;
	typedef logic [3:0] tap_t;
	typedef logic [3:0] pool_idx_t;

	localparam int IMG_DIM = 8;
	localparam int KER_DIM = 3;
	localparam int CONV_DIM = 6;
	localparam int POOL_DIM = 3;
	localparam int FRAC_BITS = 8;

	// one finished convolution output
	typedef struct packed {
		logic valid;
		coord_t row;
		coord_t col;
		pixel_t data;
	} conv_res_t;

	typedef enum logic [2:0] {
		IDLE,
		CONV,
		DRAIN,
		POOL,
		DONE
	} layer_state_t;

endpackage
